/* hw/qsim_pkg.sv */
`default_nettype none

package qsim_pkg;

	localparam int NUM_QUBIT = 4;
	localparam int NUM_PAIR = 2 ** NUM_QUBIT;          // Phase bits carried per row
	localparam int QUBIT_IDX_W = $clog2(NUM_QUBIT);
	localparam int COMPLEX_W = 24;
	localparam int FRAC_W = 22;                        // Q2.22 amplitudes
	localparam int PHASE_IDX_W = 5;
	localparam int PHASE_IDX_OFFSET = 2;               // ROM entry 0 is k = 2

	typedef logic [QUBIT_IDX_W-1:0] qubit_idx_t;
	typedef logic [NUM_QUBIT-1:0] amp_addr_t;
	typedef logic [NUM_QUBIT:0] amp_count_t;           // Up to NUM_PAIR amplitudes
	typedef logic [NUM_QUBIT:0] row_count_t;
	typedef logic [PHASE_IDX_W-1:0] phase_idx_t;
	typedef logic signed [COMPLEX_W-1:0] amp_t;
	typedef logic [NUM_QUBIT-1:0] flag_vec_t;

	// Real part sits in the upper half
	typedef struct packed {
		amp_t re;
		amp_t im;
	} complex_t;

	typedef struct packed {
		logic [NUM_QUBIT-1:0][1:0] literals;
		logic [NUM_PAIR-1:0] phase;
	} tableau_row_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_CONTROL,
		SEQ_TARGET
	} seq_state_t;

	typedef enum logic [1:0] {
		FLAG_IDLE,
		FLAG_SHIFT,
		FLAG_HOLD
	} flag_state_t;

	typedef enum logic [1:0] {
		UPD_IDLE,
		UPD_WAIT_DONE,
		UPD_WAIT_BETA,
		UPD_READ
	} upd_state_t;

endpackage

`default_nettype wire

/* hw/phase_rom.sv */
`default_nettype none

module phase_rom import qsim_pkg::*; (
	input  wire logic       clk,
	input  wire phase_idx_t addr_i,
	output complex_t        q_o
);

	// Entry a holds cos and sin of 2*pi/2^(a+2) in Q2.22
	always_ff @(posedge clk)
	begin
		case (addr_i)
			5'd0:  q_o <= {24'sd0, 24'sd4194304};          // k = 2, pure i
			5'd1:  q_o <= {24'sd2965821, 24'sd2965821};
			5'd2:  q_o <= {24'sd3875032, 24'sd1605091};
			5'd3:  q_o <= {24'sd4113712, 24'sd818268};
			5'd4:  q_o <= {24'sd4174107, 24'sd411114};
			5'd5:  q_o <= {24'sd4189252, 24'sd205805};
			5'd6:  q_o <= {24'sd4193041, 24'sd102933};
			5'd7:  q_o <= {24'sd4193988, 24'sd51471};
			5'd8:  q_o <= {24'sd4194225, 24'sd25736};
			5'd9:  q_o <= {24'sd4194284, 24'sd12868};
			5'd10: q_o <= {24'sd4194299, 24'sd6434};
			5'd11: q_o <= {24'sd4194303, 24'sd3217};
			// From here the real part rounds to one
			5'd12: q_o <= {24'sd4194304, 24'sd1608};
			5'd13: q_o <= {24'sd4194304, 24'sd804};
			5'd14: q_o <= {24'sd4194304, 24'sd402};
			5'd15: q_o <= {24'sd4194304, 24'sd201};
			5'd16: q_o <= {24'sd4194304, 24'sd101};
			5'd17: q_o <= {24'sd4194304, 24'sd50};
			5'd18: q_o <= {24'sd4194304, 24'sd25};
			5'd19: q_o <= {24'sd4194304, 24'sd13};
			5'd20: q_o <= {24'sd4194304, 24'sd6};
			5'd21: q_o <= {24'sd4194304, 24'sd3};
			5'd22: q_o <= {24'sd4194304, 24'sd2};
			5'd23: q_o <= {24'sd4194304, 24'sd1};
			default: q_o <= {24'sd4194304, 24'sd0};      // k = 26 to 33, phase below one LSB
		endcase
	end

endmodule

`default_nettype wire

/* hw/complex_mult.sv */
`default_nettype none

module complex_mult import qsim_pkg::*; (
	input  wire complex_t a_i,
	input  wire complex_t b_i,
	output complex_t      p_o
);

	localparam int PROD_W = 2 * COMPLEX_W + 1;   // Room for the sum of two products

	logic signed [PROD_W-1:0] prod_re;
	logic signed [PROD_W-1:0] prod_im;
	logic signed [PROD_W-1:0] scaled_re;
	logic signed [PROD_W-1:0] scaled_im;

	// Full precision, Q4.44
	assign prod_re = $signed(a_i.re) * $signed(b_i.re) - $signed(a_i.im) * $signed(b_i.im);
	assign prod_im = $signed(a_i.re) * $signed(b_i.im) + $signed(a_i.im) * $signed(b_i.re);

	// Back to Q2.22 by truncation
	assign scaled_re = prod_re >>> FRAC_W;
	assign scaled_im = prod_im >>> FRAC_W;

	assign p_o.re = scaled_re[COMPLEX_W-1:0];
	assign p_o.im = scaled_im[COMPLEX_W-1:0];

endmodule

`default_nettype wire

/* hw/cofactor_sequencer.sv */
`default_nettype none

module cofactor_sequencer import qsim_pkg::*; (
	input  wire logic         clk,
	input  wire logic         rst,
	input  wire logic         gate_valid_i,
	input  wire tableau_row_t gate_row_i,
	input  wire logic         buf_valid_i,
	input  wire tableau_row_t buf_row_i,
	input  wire logic         cof_ret_valid_i,
	input  wire tableau_row_t cof_ret_row_i,
	input  wire qubit_idx_t   pos1_i,
	input  wire qubit_idx_t   pos2_i,
	output logic              cof_valid_o,
	output tableau_row_t      cof_row_o,
	output qubit_idx_t        cofactor_pos_o,
	output logic              mask_valid_buffer_o,
	output logic              final_cofactor_o,
	output logic              valid_o,
	output tableau_row_t      row_o,
	output seq_state_t        state_o,
	output logic              target_done_o
);

	seq_state_t state;
	row_count_t row_cnt;
	logic       cnt_strobe;
	logic       cnt_full;

	// Gate rows are counted while idle, cofactor returns during the passes
	assign cnt_strobe = (state == SEQ_IDLE) ? gate_valid_i : cof_ret_valid_i;
	assign cnt_full = (row_cnt == row_count_t'(NUM_QUBIT));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= SEQ_IDLE;
			row_cnt <= '0;
		end
		else if (cnt_full)
		begin
			row_cnt <= '0;   // Strobe in this cycle is not counted
			case (state)
				SEQ_IDLE:    state <= SEQ_CONTROL;
				SEQ_CONTROL: state <= SEQ_TARGET;
				default:     state <= SEQ_IDLE;
			endcase
		end
		else if (cnt_strobe)
		begin
			row_cnt <= row_cnt + 1'b1;
		end
	end

	// Cofactor unit input mux
	always_comb
	begin
		case (state)
			SEQ_IDLE:
			begin
				cof_valid_o = gate_valid_i;
				cof_row_o = gate_row_i;
			end
			SEQ_CONTROL,
			SEQ_TARGET:
			begin
				cof_valid_o = buf_valid_i;   // Rows come back through the stabilizer buffer
				cof_row_o = buf_row_i;
			end
			default:
			begin
				cof_valid_o = 1'b0;
				cof_row_o = gate_row_i;
			end
		endcase
	end

	// Control qubit first, target qubit in the second pass
	assign cofactor_pos_o = (state == SEQ_TARGET) ? pos2_i : pos1_i;

	assign mask_valid_buffer_o = (state == SEQ_CONTROL) || (state == SEQ_TARGET);
	assign final_cofactor_o = (state == SEQ_TARGET);

	// Gate result is the second cofactor pass
	assign valid_o = (state == SEQ_TARGET) && cof_ret_valid_i;
	assign row_o = (state == SEQ_TARGET) ? cof_ret_row_i : '0;

	assign target_done_o = (state == SEQ_TARGET) && cnt_full;
	assign state_o = state;

endmodule

`default_nettype wire

/* hw/cofactor_flagger.sv */
`default_nettype none

module cofactor_flagger import qsim_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       gate_valid_i,
	input  wire seq_state_t seq_state_i,
	input  wire logic       target_done_i,
	input  wire qubit_idx_t pos1_i,
	input  wire qubit_idx_t pos2_i,
	output flag_vec_t       flag_cofactor_o
);

	flag_state_t state;
	qubit_idx_t  shift_idx;
	logic        sel_bit;

	// Marks the control and the target qubit
	assign sel_bit = (shift_idx == pos1_i) || (shift_idx == pos2_i);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= FLAG_IDLE;
			shift_idx <= '0;
			flag_cofactor_o <= '0;
		end
		else
		begin
			case (state)
				FLAG_IDLE:
				begin
					shift_idx <= '0;
					if (gate_valid_i && (seq_state_i == SEQ_IDLE))   // First row of a new gate
						state <= FLAG_SHIFT;
				end
				FLAG_SHIFT:
				begin
					// Index 0 enters first and ends up in bit 0
					flag_cofactor_o <= {sel_bit, flag_cofactor_o[NUM_QUBIT-1:1]};
					shift_idx <= shift_idx + 1'b1;
					if (shift_idx == qubit_idx_t'(NUM_QUBIT - 1))
						state <= FLAG_HOLD;
				end
				FLAG_HOLD:
				begin
					if (target_done_i)
						state <= FLAG_IDLE;
				end
				default:
				begin
					state <= FLAG_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/amplitude_updater.sv */
`default_nettype none

module amplitude_updater import qsim_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire seq_state_t seq_state_i,
	input  wire logic       cof_ret_valid_i,
	input  wire phase_idx_t phase_shift_index_i,
	input  wire logic       done_flag_i,
	input  wire logic       updating_beta_i,
	input  wire amp_count_t amp_count_i,
	input  wire logic       update_flag_i,
	input  wire complex_t   rd_data_i,
	output logic            rd_en_o,
	output amp_addr_t       rd_addr_o,
	output logic            rotate_flag_o,
	output logic            wr_en_o,
	output amp_addr_t       wr_addr_o,
	output complex_t        wr_data_o
);

	upd_state_t state;
	amp_count_t rd_cnt;
	logic       last_rd;
	phase_idx_t phase_idx_q;
	complex_t   phase_const;
	complex_t   rd_data_q;
	complex_t   product;
	logic       we_d1;
	logic       we_d2;
	amp_addr_t  addr_d1;
	amp_addr_t  addr_d2;

	assign rd_en_o = ((state == UPD_WAIT_BETA) && !updating_beta_i) || (state == UPD_READ);
	assign rd_addr_o = rd_cnt[NUM_QUBIT-1:0];
	assign rotate_flag_o = rd_en_o;   // Flag source steps with every read
	assign last_rd = (amp_count_t'(rd_cnt + 1'b1) == amp_count_i);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= UPD_IDLE;
			rd_cnt <= '0;
		end
		else
		begin
			case (state)
				UPD_IDLE:
				begin
					rd_cnt <= '0;
					if ((seq_state_i == SEQ_CONTROL) && cof_ret_valid_i)
						state <= UPD_WAIT_DONE;
				end
				UPD_WAIT_DONE:
				begin
					if (done_flag_i)
						state <= UPD_WAIT_BETA;
				end
				UPD_WAIT_BETA,
				UPD_READ:
				begin
					// Beta update of the last cofactor must be finished first
					if (rd_en_o && last_rd)
					begin
						state <= UPD_IDLE;
						rd_cnt <= '0;
					end
					else if (rd_en_o)
					begin
						state <= UPD_READ;
						rd_cnt <= rd_cnt + 1'b1;
					end
				end
				default:
				begin
					state <= UPD_IDLE;
				end
			endcase
		end
	end

	// Phase index is stable for the whole gate
	always_ff @(posedge clk)
	begin
		if (seq_state_i == SEQ_CONTROL)
			phase_idx_q <= phase_shift_index_i - phase_idx_t'(PHASE_IDX_OFFSET);
	end

	phase_rom u_phase_rom (
		.clk    (clk),
		.addr_i (phase_idx_q),
		.q_o    (phase_const)
	);

	complex_mult u_complex_mult (
		.a_i (phase_const),
		.b_i (rd_data_q),
		.p_o (product)
	);

	// Read, RAM data, multiply, write
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			we_d1 <= 1'b0;
			we_d2 <= 1'b0;
			wr_en_o <= 1'b0;
		end
		else
		begin
			we_d1 <= rd_en_o && update_flag_i;   // Unflagged amplitudes are left alone
			we_d2 <= we_d1;
			wr_en_o <= we_d2;
		end
	end

	always_ff @(posedge clk)
	begin
		addr_d1 <= rd_addr_o;
		addr_d2 <= addr_d1;
		wr_addr_o <= addr_d2;
		rd_data_q <= rd_data_i;
		wr_data_o <= product;
	end

endmodule

`default_nettype wire

/* hw/nonstab_phase_shift_top.sv */
`default_nettype none

module nonstab_phase_shift_top import qsim_pkg::*; (
	input  wire logic         clk,
	input  wire logic         rst,
	input  wire logic         gate_valid_i,
	input  wire tableau_row_t gate_row_i,
	input  wire logic         buf_valid_i,
	input  wire tableau_row_t buf_row_i,
	input  wire logic         cof_ret_valid_i,
	input  wire tableau_row_t cof_ret_row_i,
	input  wire qubit_idx_t   pos1_i,
	input  wire qubit_idx_t   pos2_i,
	input  wire phase_idx_t   phase_shift_index_i,
	input  wire logic         done_flag_i,
	input  wire logic         updating_beta_i,
	input  wire amp_count_t   amp_count_i,
	input  wire logic         update_flag_i,
	input  wire complex_t     rd_data_i,
	output logic              cof_valid_o,
	output tableau_row_t      cof_row_o,
	output qubit_idx_t        cofactor_pos_o,
	output logic              mask_valid_buffer_o,
	output logic              final_cofactor_o,
	output logic              valid_o,
	output tableau_row_t      row_o,
	output flag_vec_t         flag_cofactor_o,
	output logic              rd_en_o,
	output amp_addr_t         rd_addr_o,
	output logic              rotate_flag_o,
	output logic              wr_en_o,
	output amp_addr_t         wr_addr_o,
	output complex_t          wr_data_o
);

	seq_state_t seq_state;
	logic       target_done;

	cofactor_sequencer u_sequencer (
		.clk                 (clk),
		.rst                 (rst),
		.gate_valid_i        (gate_valid_i),
		.gate_row_i          (gate_row_i),
		.buf_valid_i         (buf_valid_i),
		.buf_row_i           (buf_row_i),
		.cof_ret_valid_i     (cof_ret_valid_i),
		.cof_ret_row_i       (cof_ret_row_i),
		.pos1_i              (pos1_i),
		.pos2_i              (pos2_i),
		.cof_valid_o         (cof_valid_o),
		.cof_row_o           (cof_row_o),
		.cofactor_pos_o      (cofactor_pos_o),
		.mask_valid_buffer_o (mask_valid_buffer_o),
		.final_cofactor_o    (final_cofactor_o),
		.valid_o             (valid_o),
		.row_o               (row_o),
		.state_o             (seq_state),
		.target_done_o       (target_done)
	);

	cofactor_flagger u_flagger (
		.clk             (clk),
		.rst             (rst),
		.gate_valid_i    (gate_valid_i),
		.seq_state_i     (seq_state),
		.target_done_i   (target_done),
		.pos1_i          (pos1_i),
		.pos2_i          (pos2_i),
		.flag_cofactor_o (flag_cofactor_o)
	);

	amplitude_updater u_updater (
		.clk                 (clk),
		.rst                 (rst),
		.seq_state_i         (seq_state),
		.cof_ret_valid_i     (cof_ret_valid_i),
		.phase_shift_index_i (phase_shift_index_i),
		.done_flag_i         (done_flag_i),
		.updating_beta_i     (updating_beta_i),
		.amp_count_i         (amp_count_i),
		.update_flag_i       (update_flag_i),
		.rd_data_i           (rd_data_i),
		.rd_en_o             (rd_en_o),
		.rd_addr_o           (rd_addr_o),
		.rotate_flag_o       (rotate_flag_o),
		.wr_en_o             (wr_en_o),
		.wr_addr_o           (wr_addr_o),
		.wr_data_o           (wr_data_o)
	);

endmodule

`default_nettype wire

/* verif/tb_nonstab_phase_shift.sv */
`default_nettype none

module tb_nonstab_phase_shift import qsim_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_TESTS = 4;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int GATE_LIMIT = 200;         // Cycles allowed for one gate or one update
	localparam real PI = 3.14159265358979;

	logic         clk;
	logic         rst;
	logic         gate_valid_i;
	tableau_row_t gate_row_i;
	logic         buf_valid_i;
	tableau_row_t buf_row_i;
	logic         cof_ret_valid_i;
	tableau_row_t cof_ret_row_i;
	qubit_idx_t   pos1_i;
	qubit_idx_t   pos2_i;
	phase_idx_t   phase_shift_index_i;
	logic         done_flag_i;
	logic         updating_beta_i;
	amp_count_t   amp_count_i;
	logic         update_flag_i;
	complex_t     rd_data_i;
	logic         cof_valid_o;
	tableau_row_t cof_row_o;
	qubit_idx_t   cofactor_pos_o;
	logic         mask_valid_buffer_o;
	logic         final_cofactor_o;
	logic         valid_o;
	tableau_row_t row_o;
	flag_vec_t    flag_cofactor_o;
	logic         rd_en_o;
	amp_addr_t    rd_addr_o;
	logic         rotate_flag_o;
	logic         wr_en_o;
	amp_addr_t    wr_addr_o;
	complex_t     wr_data_o;

	logic [31:0]         lfsr_state;
	int                  num_errors;
	int                  tests_failed;
	complex_t            ram [NUM_PAIR];
	complex_t            ram_init [NUM_PAIR];
	logic [NUM_PAIR-1:0] flag_seq;
	int                  flag_ptr;
	int                  rd_expect;
	int                  wr_count;
	logic [NUM_QUBIT:0]  wr_hist [3];       // Write enable and address of recent reads
	tableau_row_t        out_expect [$];
	logic                cof_stage_v;
	tableau_row_t        cof_stage_row;
	logic [1:0]          buf_key;
	int                  buf_sent;

	nonstab_phase_shift_top DUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// e^(i*2*pi/2^k) rounded to Q2.22
	function automatic complex_t phase_constant(input int k);
		real      ang;
		complex_t c;
		ang = 2.0 * PI / (2.0 ** k);
		c.re = amp_t'($rtoi($cos(ang) * (2.0 ** FRAC_W) + 0.5));
		c.im = amp_t'($rtoi($sin(ang) * (2.0 ** FRAC_W) + 0.5));
		return c;
	endfunction

	function automatic complex_t phase_product(input complex_t c, input complex_t a);
		longint   re_full;
		longint   im_full;
		complex_t p;
		re_full = longint'($signed(c.re)) * longint'($signed(a.re))
			- longint'($signed(c.im)) * longint'($signed(a.im));
		im_full = longint'($signed(c.re)) * longint'($signed(a.im))
			+ longint'($signed(c.im)) * longint'($signed(a.re));
		p.re = amp_t'(re_full >>> FRAC_W);   // Truncate back to the amplitude format
		p.im = amp_t'(im_full >>> FRAC_W);
		return p;
	endfunction

	task automatic note_failure(input string what);
		$display("%0t ns: %s", $time, what);
		num_errors++;
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			num_errors++;
		end
	endtask

	task automatic compare_row(input string name, input tableau_row_t got,
		input tableau_row_t exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			num_errors++;
		end
	endtask

	task automatic compare_pos(input string name, input qubit_idx_t got, input qubit_idx_t exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			num_errors++;
		end
	endtask

	task automatic compare_flags(input string name, input flag_vec_t got, input flag_vec_t exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			num_errors++;
		end
	endtask

	task automatic compare_addr(input string name, input amp_addr_t got, input amp_addr_t exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			num_errors++;
		end
	endtask

	task automatic compare_complex(input string name, input complex_t got, input complex_t exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is (%0d, %0d), expected (%0d, %0d)", $time, name,
				$signed(got.re), $signed(got.im), $signed(exp.re), $signed(exp.im));
			num_errors++;
		end
	endtask

	// Cofactor unit, returns pass rows two cycles later
	always
	begin : cofactor_model
		logic         sent_v;
		tableau_row_t sent_row;
		@(negedge clk);
		sent_v = cof_valid_o && mask_valid_buffer_o;   // Gate rows only load the unit
		sent_row = cof_row_o;
		@(posedge clk);
		#1;
		cof_ret_valid_i = cof_stage_v;
		cof_ret_row_i = cof_stage_row;
		cof_stage_v = sent_v;
		cof_stage_row = sent_row;
	end

	// Stabilizer buffer, NUM_QUBIT rows per pass
	always
	begin : buffer_model
		logic [1:0]   pass_key;
		logic         emit;
		tableau_row_t row;
		@(negedge clk);
		pass_key = {mask_valid_buffer_o, final_cofactor_o};
		if (pass_key != buf_key)
			buf_sent = 0;
		buf_key = pass_key;
		emit = mask_valid_buffer_o && (buf_sent < NUM_QUBIT);
		row = '0;
		if (emit)
		begin
			row = tableau_row_t'(rand_bits(24));
			buf_sent++;
			if (final_cofactor_o)
				out_expect.push_back(row);   // Second pass rows leave on row_o
		end
		@(posedge clk);
		#1;
		buf_valid_i = emit;
		buf_row_i = row;
	end

	// Amplitude RAM and flag source
	always
	begin : ram_model
		logic      rd_v;
		amp_addr_t rd_a;
		@(negedge clk);
		rd_v = rd_en_o;
		rd_a = rd_addr_o;
		if (wr_en_o)
			ram[wr_addr_o] = wr_data_o;
		if (rotate_flag_o)
			flag_ptr++;
		@(posedge clk);
		#1;
		if (rd_v)
			rd_data_i = ram[rd_a];
		update_flag_i = flag_seq[flag_ptr % NUM_PAIR];
	end

	// Read order and the read-to-write distance
	always
	begin : access_monitor
		@(negedge clk);
		if (!rst)
		begin
			if (rd_en_o)
			begin
				if (updating_beta_i)
					compare_bit("rd_en_o", rd_en_o, 1'b0);
				compare_addr("rd_addr_o", rd_addr_o, amp_addr_t'(rd_expect));
				rd_expect++;
			end
			compare_bit("wr_en_o", wr_en_o, wr_hist[2][NUM_QUBIT]);
			if (wr_en_o)
			begin
				compare_addr("wr_addr_o", wr_addr_o, wr_hist[2][NUM_QUBIT-1:0]);
				wr_count++;
			end
			wr_hist[2] = wr_hist[1];
			wr_hist[1] = wr_hist[0];
			wr_hist[0] = {rd_en_o && update_flag_i, rd_addr_o};
		end
	end

	task automatic pick_positions(output qubit_idx_t p1, output qubit_idx_t p2);
		p1 = qubit_idx_t'(rand_bits(2));
		p2 = qubit_idx_t'(rand_bits(2));
		if (p2 == p1)
			p2 = p1 + 1'b1;
	endtask

	// One gate: NUM_QUBIT rows in, control pass, target pass
	task automatic run_gate(input qubit_idx_t p1, input qubit_idx_t p2);
		tableau_row_t row;
		flag_vec_t    flags_exp;
		int           pass;         // 0 idle, 1 control, 2 target, 3 done
		int           pass_ret;
		int           tgt_ret;
		int           hold;
		bit           finished;
		flags_exp = '0;
		flags_exp[p1] = 1'b1;
		flags_exp[p2] = 1'b1;
		pass = 0;
		pass_ret = 0;
		tgt_ret = 0;
		hold = 2;                   // Gate count completes first, then the control pass
		finished = 1'b0;
		out_expect.delete();
		@(posedge clk);
		#1;
		pos1_i = p1;
		pos2_i = p2;
		for (int i = 0; i < NUM_QUBIT; i++)
		begin
			@(posedge clk);
			#1;
			row = tableau_row_t'(rand_bits(24));
			gate_valid_i = 1'b1;
			gate_row_i = row;
			@(negedge clk);
			compare_bit("cof_valid_o", cof_valid_o, 1'b1);
			compare_row("cof_row_o", cof_row_o, row);
			compare_bit("mask_valid_buffer_o", mask_valid_buffer_o, 1'b0);
			compare_pos("cofactor_pos_o", cofactor_pos_o, p1);
		end
		@(posedge clk);
		#1;
		gate_valid_i = 1'b0;
		for (int c = 0; c < GATE_LIMIT && !finished; c++)
		begin
			@(negedge clk);
			// Next pass begins two cycles after the last row of this one
			if (hold > 0)
			begin
				hold--;
				if (hold == 0)
				begin
					pass++;
					pass_ret = 0;
				end
			end
			compare_bit("mask_valid_buffer_o", mask_valid_buffer_o, pass == 1 || pass == 2);
			compare_bit("final_cofactor_o", final_cofactor_o, pass == 2);
			compare_pos("cofactor_pos_o", cofactor_pos_o, (pass == 2) ? p2 : p1);
			compare_bit("valid_o", valid_o, (pass == 2) && cof_ret_valid_i);
			if (pass == 1 || pass == 2)
			begin
				compare_flags("flag_cofactor_o", flag_cofactor_o, flags_exp);
				compare_bit("cof_valid_o", cof_valid_o, buf_valid_i);
				if (buf_valid_i)
					compare_row("cof_row_o", cof_row_o, buf_row_i);
				if (cof_ret_valid_i)
				begin
					pass_ret++;
					if (pass_ret == NUM_QUBIT)
						hold = 2;
				end
			end
			else
			begin
				compare_bit("cof_valid_o", cof_valid_o, 1'b0);
			end
			if (pass == 2 && cof_ret_valid_i)
			begin
				tgt_ret++;
				if (out_expect.size() == 0)
					note_failure("valid_o rose with no buffer row left to return");
				else
					compare_row("row_o", row_o, out_expect.pop_front());
			end
			finished = (pass == 3);
		end
		if (!finished)
		begin
			note_failure("gate did not finish in time");
		end
		else
		begin
			if (tgt_ret != NUM_QUBIT || out_expect.size() != 0)
				note_failure($sformatf("second pass returned %0d rows", tgt_ret));
		end
	endtask

	task automatic test_reset();
		@(negedge clk);
		compare_bit("cof_valid_o", cof_valid_o, 1'b0);
		compare_bit("mask_valid_buffer_o", mask_valid_buffer_o, 1'b0);
		compare_bit("final_cofactor_o", final_cofactor_o, 1'b0);
		compare_bit("valid_o", valid_o, 1'b0);
		compare_bit("rd_en_o", rd_en_o, 1'b0);
		compare_bit("rotate_flag_o", rotate_flag_o, 1'b0);
		compare_bit("wr_en_o", wr_en_o, 1'b0);
		compare_flags("flag_cofactor_o", flag_cofactor_o, '0);
	endtask

	task automatic test_gate_sequence();
		run_gate(2'd0, 2'd3);
	endtask

	task automatic test_flags();
		qubit_idx_t p1;
		qubit_idx_t p2;
		for (int g = 0; g < 3; g++)
		begin
			pick_positions(p1, p2);
			run_gate(p1, p2);
		end
	endtask

	task automatic test_amplitude_update();
		phase_idx_t  phase;
		amp_count_t  count;
		qubit_idx_t  p1;
		qubit_idx_t  p2;
		logic [22:0] rnd;
		int          beta_cycles;
		int          exp_writes;
		complex_t    konst;
		@(posedge clk);
		#1;
		phase = phase_idx_t'(rand_bits(5));
		if (phase < PHASE_IDX_OFFSET)
			phase = phase + phase_idx_t'(PHASE_IDX_OFFSET);
		count = amp_count_t'(rand_bits(4)) + 1'b1;
		// Amplitudes of magnitude below one
		for (int a = 0; a < NUM_PAIR; a++)
		begin
			rnd = rand_bits(23);
			ram_init[a].re = amp_t'($signed(rnd));
			rnd = rand_bits(23);
			ram_init[a].im = amp_t'($signed(rnd));
			ram[a] = ram_init[a];
		end
		flag_seq = rand_bits(NUM_PAIR);
		flag_ptr = 0;
		phase_shift_index_i = phase;
		amp_count_i = count;
		pick_positions(p1, p2);
		run_gate(p1, p2);
		@(posedge clk);
		#1;
		rd_expect = 0;
		wr_count = 0;
		beta_cycles = 1 + int'(rand_bits(4));
		done_flag_i = 1'b1;
		updating_beta_i = 1'b1;
		@(posedge clk);
		#1;
		done_flag_i = 1'b0;
		repeat (beta_cycles) @(posedge clk);
		#1;
		updating_beta_i = 1'b0;
		for (int w = 0; w < GATE_LIMIT && rd_expect < count; w++)
			@(posedge clk);
		repeat (6) @(posedge clk);   // Last writes drain
		#1;
		if (rd_expect != count)
			note_failure($sformatf("%0d reads seen, %0d expected", rd_expect, count));
		exp_writes = 0;
		konst = phase_constant(phase);
		for (int a = 0; a < NUM_PAIR; a++)
		begin
			if (a < count && flag_seq[a])
			begin
				exp_writes++;
				compare_complex($sformatf("wr_data_o[%0d]", a), ram[a],
					phase_product(konst, ram_init[a]));
			end
			else
			begin
				compare_complex($sformatf("ram[%0d]", a), ram[a], ram_init[a]);
			end
		end
		if (wr_count != exp_writes)
			note_failure($sformatf("%0d writes seen, %0d expected", wr_count, exp_writes));
	endtask

	task automatic report_test(input string name, input int errs_before);
		int errs;
		errs = num_errors - errs_before;
		if (errs != 0)
			tests_failed++;
		$display("test %s finished with %0d errors", name, errs);
	endtask

	initial
	begin
		int errs;
		clk = 1'b0;
		rst = 1'b1;
		gate_valid_i = 1'b0;
		gate_row_i = '0;
		buf_valid_i = 1'b0;
		buf_row_i = '0;
		cof_ret_valid_i = 1'b0;
		cof_ret_row_i = '0;
		pos1_i = '0;
		pos2_i = '0;
		phase_shift_index_i = phase_idx_t'(PHASE_IDX_OFFSET);
		done_flag_i = 1'b0;
		updating_beta_i = 1'b0;
		amp_count_i = amp_count_t'(1);
		update_flag_i = 1'b0;
		rd_data_i = '0;
		lfsr_state = 32'h77a2d175;
		num_errors = 0;
		tests_failed = 0;
		flag_seq = '0;
		flag_ptr = 0;
		rd_expect = 0;
		wr_count = 0;
		wr_hist[0] = '0;
		wr_hist[1] = '0;
		wr_hist[2] = '0;
		cof_stage_v = 1'b0;
		cof_stage_row = '0;
		buf_key = '0;
		buf_sent = 0;
		for (int a = 0; a < NUM_PAIR; a++)
		begin
			ram[a] = '0;
			ram_init[a] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		errs = num_errors;
		test_reset();
		report_test("reset", errs);
		errs = num_errors;
		test_gate_sequence();
		report_test("gate_sequence", errs);
		errs = num_errors;
		test_flags();
		report_test("flags", errs);
		errs = num_errors;
		test_amplitude_update();
		report_test("amplitude_update", errs);

		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed, num_errors);
		if (num_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog expired before the tests completed");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hw/qsim_pkg.sv
hw/phase_rom.sv
hw/complex_mult.sv
hw/cofactor_sequencer.sv
hw/cofactor_flagger.sv
hw/amplitude_updater.sv
hw/nonstab_phase_shift_top.sv
verif/tb_nonstab_phase_shift.sv
